// File: Bender.yml
package:
  name: exec_subsys

sources:
  - src/exec_pkg.sv
  - src/alu.sv
  - src/bypass_file.sv
  - src/exu.sv
  - src/lsu.sv
  - src/exec_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_exec_top.sv

// File: exec_subsys.f
+incdir+tb
src/exec_pkg.sv
src/alu.sv
src/bypass_file.sv
src/exu.sv
src/lsu.sv
src/exec_top.sv
tb/tb_exec_top.sv

// File: src/alu.sv
module alu import exec_pkg::*; (
    input  alu_op_e         op,
    input  br_op_e          br_op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [XLEN-1:0] c,
    input  logic [XLEN-1:0] d,
    output logic [XLEN-1:0] result,
    output logic            taken
);
    logic [4:0] shamt;
    logic       lt_ab_s;
    logic       lt_ab_u;
    logic       eq_cd;
    logic       lt_cd_s;
    logic       lt_cd_u;

    assign shamt   = b[4:0];
    assign lt_ab_s = $signed(a) < $signed(b);
    assign lt_ab_u = a < b;

    // branch compare runs on the register operands, not on the alu inputs.
    assign eq_cd   = c == d;
    assign lt_cd_s = $signed(c) < $signed(d);
    assign lt_cd_u = c < d;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $unsigned($signed(a) >>> shamt);
            alu_slt:    result = {{(XLEN-1){1'b0}}, lt_ab_s};
            alu_sltu:   result = {{(XLEN-1){1'b0}}, lt_ab_u};
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    always_comb begin
        case (br_op)
            br_beq:  taken = eq_cd;
            br_bne:  taken = !eq_cd;
            br_blt:  taken = lt_cd_s;
            br_bge:  taken = !lt_cd_s;
            br_bltu: taken = lt_cd_u;
            br_bgeu: taken = !lt_cd_u;
            br_jal,
            br_jalr: taken = 1'b1; // jumps always leave.
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: src/bypass_file.sv
module bypass_file import exec_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic [REG_AW-1:0] push_rd,
    input  logic [XLEN-1:0]   push_data,
    input  logic              push_is_load,
    input  logic              load_done,
    input  logic [XLEN-1:0]   load_data,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    input  logic [XLEN-1:0]   rf1,
    input  logic [XLEN-1:0]   rf2,
    output logic [XLEN-1:0]   src1,
    output logic [XLEN-1:0]   src2,
    output logic              stall
);
    logic [REG_AW-1:0] ent_rd    [DEPTH];
    logic [XLEN-1:0]   ent_data  [DEPTH];
    logic [DEPTH-1:0]  ent_pend;
    logic [XLEN-1:0]   fill_data [DEPTH];
    logic [DEPTH-1:0]  fill_pend;
    logic              stall1;
    logic              stall2;

    // window contents after this cycle's load completion, before any shift.
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            fill_data[i] = (load_done && ent_pend[i]) ? load_data : ent_data[i];
        end
        fill_pend = load_done ? '0 : ent_pend; // only one load can be in flight.
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ent_rd[i] <= '0; // x0 never matches a lookup.
            end
            ent_pend <= '0;
        end else if (push) begin
            ent_rd[0]   <= push_rd;
            ent_pend[0] <= push_is_load;
            for (int i = 1; i < DEPTH; i++) begin
                ent_rd[i]   <= ent_rd[i-1];
                ent_pend[i] <= fill_pend[i-1];
            end
        end else begin
            ent_pend <= fill_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ent_data[0] <= push_data;
            for (int i = 1; i < DEPTH; i++) begin
                ent_data[i] <= fill_data[i-1];
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                ent_data[i] <= fill_data[i];
            end
        end
    end

    // oldest first, so the youngest match is the one that sticks.
    always_comb begin
        src1   = rf1;
        src2   = rf2;
        stall1 = 1'b0;
        stall2 = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (rs1 != '0 && ent_rd[i] == rs1) begin
                src1   = ent_data[i];
                stall1 = ent_pend[i];
            end
            if (rs2 != '0 && ent_rd[i] == rs2) begin
                src2   = ent_data[i];
                stall2 = ent_pend[i];
            end
        end
    end

    assign stall = stall1 | stall2;

    one_pending: assert property (@(posedge clk) disable iff (rst)
        $countones(ent_pend) <= 1);

endmodule

// File: src/exec_pkg.sv
package exec_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 4;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b // lui.
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } br_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lw,
        mem_lh,
        mem_lhu,
        mem_lb,
        mem_lbu,
        mem_sw,
        mem_sh,
        mem_sb
    } mem_op_e;

    typedef enum logic [1:0] {
        csr_none,
        csr_rw,
        csr_rs
    } csr_op_e;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   src1_r;   // register file value read at decode.
        logic [XLEN-1:0]   src2_r;
        logic [XLEN-1:0]   imm;
        alu_op_e           alu_op;
        br_op_e            br_op;
        mem_op_e           mem_op;
        csr_op_e           csr_op;
        logic [XLEN-1:0]   csr_data; // old csr value.
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              gpr_we;
    } dec_bus_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              gpr_we;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   result;     // also the memory address.
        logic [XLEN-1:0]   store_data;
        logic              csr_we;
        logic [11:0]       csr_addr;
        logic [XLEN-1:0]   csr_wdata;
    } ex_bus_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              gpr_we;
        logic [XLEN-1:0]   data;
        logic              csr_we;
        logic [11:0]       csr_addr;
        logic [XLEN-1:0]   csr_wdata;
    } wb_bus_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      wstrb;
        logic            we;
    } mem_req_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {mem_sw, mem_sh, mem_sb};
    endfunction

endpackage

// File: src/exec_top.sv
module exec_top import exec_pkg::*; #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            dec_valid,
    input  dec_bus_t        dec,
    output logic            exu_ready,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    input  logic            pc_update,
    output logic            mem_req,
    output mem_req_t        mem_addr_bus,
    input  logic            mem_ack,
    input  logic [XLEN-1:0] mem_rdata,
    output logic            wb_valid,
    output wb_bus_t         wb
);
    logic            ex_valid;
    ex_bus_t         ex;
    logic            lsu_ready;
    logic            load_done;
    logic [XLEN-1:0] load_data;

    exu #(
        .BYPASS_DEPTH (BYPASS_DEPTH)
    ) u_exu (
        .clk            (clk),
        .rst            (rst),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .exu_ready      (exu_ready),
        .ex_valid       (ex_valid),
        .ex             (ex),
        .lsu_ready      (lsu_ready),
        .load_done      (load_done),
        .load_data      (load_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc_update      (pc_update)
    );

    lsu u_lsu (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex           (ex),
        .lsu_ready    (lsu_ready),
        .mem_req      (mem_req),
        .mem_addr_bus (mem_addr_bus),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .load_done    (load_done),
        .load_data    (load_data),
        .wb_valid     (wb_valid),
        .wb           (wb)
    );

endmodule

// File: src/exu.sv
module exu import exec_pkg::*; #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            dec_valid,
    input  dec_bus_t        dec,
    output logic            exu_ready,
    output logic            ex_valid,
    output ex_bus_t         ex,
    input  logic            lsu_ready,
    input  logic            load_done,
    input  logic [XLEN-1:0] load_data,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    input  logic            pc_update
);
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            byp_stall;
    logic            load_inflight;
    logic            load_block;
    logic            accept;
    logic            live;
    logic            push;
    logic            dec_is_load;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic            taken;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] csr_wdata;
    logic            redirect_set;
    ex_bus_t         ex_d;

    assign dec_is_load = is_load(dec.mem_op);

    // a second load waits until the first one has returned its data.
    assign load_block = dec_is_load && load_inflight && !load_done;
    assign exu_ready  = !(ex_valid && !lsu_ready) && !byp_stall && !load_block;
    assign accept     = dec_valid && exu_ready;
    assign live       = accept && !redirect_valid; // squashed while a redirect is out.
    assign push       = live && dec.gpr_we;

    bypass_file #(
        .DEPTH (BYPASS_DEPTH)
    ) u_bypass (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .push_rd      (dec.rd),
        .push_data    (result),
        .push_is_load (dec_is_load),
        .load_done    (load_done),
        .load_data    (load_data),
        .rs1          (dec.rs1),
        .rs2          (dec.rs2),
        .rf1          (dec.src1_r),
        .rf2          (dec.src2_r),
        .src1         (src1),
        .src2         (src2),
        .stall        (byp_stall)
    );

    assign alu_a = dec.src1_is_pc ? dec.pc : src1;
    assign alu_b = dec.src2_is_imm ? dec.imm : src2;

    alu u_alu (
        .op     (dec.alu_op),
        .br_op  (dec.br_op),
        .a      (alu_a),
        .b      (alu_b),
        .c      (src1),
        .d      (src2),
        .result (alu_res),
        .taken  (taken)
    );

    assign pc_plus4 = dec.pc + 32'd4;
    assign target   = (dec.br_op == br_jalr) ? alu_res : dec.pc + dec.imm;

    always_comb begin
        if (dec.br_op inside {br_jal, br_jalr}) begin
            result = pc_plus4; // link value.
        end else if (dec.csr_op != csr_none) begin
            result = dec.csr_data;
        end else begin
            result = alu_res;
        end
        case (dec.csr_op)
            csr_rw:  csr_wdata = src1;
            csr_rs:  csr_wdata = src1 | dec.csr_data;
            default: csr_wdata = '0;
        endcase
    end

    always_comb begin
        ex_d.pc         = dec.pc;
        ex_d.rd         = dec.rd;
        ex_d.gpr_we     = dec.gpr_we;
        ex_d.mem_op     = dec.mem_op;
        ex_d.result     = result;
        ex_d.store_data = src2;
        ex_d.csr_we     = dec.csr_op != csr_none;
        ex_d.csr_addr   = dec.imm[11:0];
        ex_d.csr_wdata  = csr_wdata;
    end

    assign redirect_set = live && taken && (target != pc_plus4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid       <= 1'b0;
            redirect_valid <= 1'b0;
            load_inflight  <= 1'b0;
        end else begin
            if (accept) begin
                ex_valid <= !redirect_valid;
            end else if (lsu_ready) begin
                ex_valid <= 1'b0;
            end
            if (redirect_set) begin
                redirect_valid <= 1'b1;
            end else if (pc_update) begin
                redirect_valid <= 1'b0;
            end
            if (live && dec_is_load) begin
                load_inflight <= 1'b1;
            end else if (load_done) begin
                load_inflight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex <= ex_d;
        end
        if (redirect_set) begin
            redirect_pc <= target;
        end
    end

    load_tracked: assert property (@(posedge clk) disable iff (rst)
        load_done |-> load_inflight);

endmodule

// File: src/lsu.sv
module lsu import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            ex_valid,
    input  ex_bus_t         ex,
    output logic            lsu_ready,
    output logic            mem_req,
    output mem_req_t        mem_addr_bus,
    input  logic            mem_ack,
    input  logic [XLEN-1:0] mem_rdata,
    output logic            load_done,
    output logic [XLEN-1:0] load_data,
    output logic            wb_valid,
    output wb_bus_t         wb
);
    typedef enum logic [1:0] {
        idle,
        req,
        wait_release
    } state_e;

    state_e          state;
    ex_bus_t         cur;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] ld_val;
    logic [1:0]      ofs;
    logic            take;
    logic            is_mem;
    logic            release_done;
    mem_req_t        req_d;

    function automatic logic [XLEN-1:0] extract(mem_op_e op, logic [1:0] a,
                                                logic [XLEN-1:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{a, 3'b000} +: 8];
        h = a[1] ? word[31:16] : word[15:0];
        case (op)
            mem_lb:  return {{24{b[7]}}, b};
            mem_lbu: return {24'd0, b};
            mem_lh:  return {{16{h[15]}}, h};
            mem_lhu: return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic wb_bus_t to_wb(ex_bus_t e, logic [XLEN-1:0] data);
        wb_bus_t w;
        w.pc        = e.pc;
        w.rd        = e.rd;
        w.gpr_we    = e.gpr_we;
        w.data      = data;
        w.csr_we    = e.csr_we;
        w.csr_addr  = e.csr_addr;
        w.csr_wdata = e.csr_wdata;
        return w;
    endfunction

    assign lsu_ready    = state == idle;
    assign take         = ex_valid && lsu_ready;
    assign is_mem       = ex.mem_op != mem_none;
    assign release_done = state == wait_release && !mem_ack; // fourth phase seen.
    assign ofs          = ex.result[1:0];

    always_comb begin
        req_d.addr  = ex.result;
        req_d.we    = is_store(ex.mem_op);
        req_d.wdata = ex.store_data << {ofs, 3'b000}; // move into the addressed lanes.
        case (ex.mem_op)
            mem_sw:  req_d.wstrb = 4'b1111;
            mem_sh:  req_d.wstrb = 4'b0011 << ofs;
            mem_sb:  req_d.wstrb = 4'b0001 << ofs;
            default: req_d.wstrb = 4'b0000;
        endcase
    end

    assign ld_val    = extract(cur.mem_op, cur.result[1:0], rdata_q);
    assign load_data = wb.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            mem_req   <= 1'b0;
            wb_valid  <= 1'b0;
            load_done <= 1'b0;
        end else begin
            wb_valid  <= 1'b0;
            load_done <= 1'b0;
            case (state)
                idle: begin
                    if (take && is_mem) begin
                        state   <= req;
                        mem_req <= 1'b1;
                    end else if (take) begin
                        wb_valid <= 1'b1;
                    end
                end
                req: begin
                    if (mem_ack) begin
                        state   <= wait_release;
                        mem_req <= 1'b0;
                    end
                end
                wait_release: begin
                    if (!mem_ack) begin
                        state     <= idle;
                        wb_valid  <= 1'b1;
                        load_done <= is_load(cur.mem_op);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur          <= ex;
            mem_addr_bus <= req_d;
        end
        if (state == req && mem_ack) begin
            rdata_q <= mem_rdata; // valid only while ack is high.
        end
        if (take && !is_mem) begin
            wb <= to_wb(ex, ex.result);
        end else if (release_done) begin
            wb <= to_wb(cur, is_load(cur.mem_op) ? ld_val : cur.result);
        end
    end

    req_after_release: assert property (@(posedge clk) disable iff (rst)
        !mem_req && mem_ack |=> !mem_req);

endmodule

// File: tb/tb_exec_tests.svh
function automatic logic [31:0] expect_alu(input alu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    case (op)
        alu_add:  return a + b;
        alu_sub:  return a + ~b + 32'd1;
        alu_and:  return a & b;
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_sll:  return a << b[4:0];
        alu_srl:  return a >> b[4:0];
        alu_sra:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
        alu_slt:  return (a[31] != b[31]) ? a[31] : (a < b); // sign decides first.
        alu_sltu: return a < b;
        default:  return b;
    endcase
endfunction

function automatic logic [31:0] expect_load(input mem_op_e op, input logic [1:0] ofs,
                                            input logic [31:0] word);
    logic [31:0] s;
    s = word >> (8 * ofs);
    case (op)
        mem_lb:  return {{24{s[7]}}, s[7:0]};
        mem_lbu: return s & 32'h0000_00ff;
        mem_lh:  return {{16{s[15]}}, s[15:0]};
        mem_lhu: return s & 32'h0000_ffff;
        default: return word;
    endcase
endfunction

task automatic test_alu();
    dec_bus_t d;
    wb_bus_t  w;
    alu_op_e  op;
    set_reg(1, 32'hf0f0_1234);
    set_reg(2, 32'h0000_0013);
    for (int i = 0; i <= int'(alu_pass_b); i++) begin
        op       = alu_op_e'(i);
        d        = base_op(32'h100, 3, 1, 2);
        d.alu_op = op;
        issue(d);
        take_wb(w);
        check_value({"wb.data ", op.name()}, w.data, expect_alu(op, 32'hf0f0_1234, 32'h13));
        d.src2_is_imm = 1'b1;
        d.imm         = 32'hffff_f805;
        issue(d);
        take_wb(w);
        check_value({"wb.data imm ", op.name()}, w.data,
                    expect_alu(op, 32'hf0f0_1234, 32'hffff_f805));
        d.src1_is_pc = 1'b1; // auipc style.
        issue(d);
        take_wb(w);
        check_value({"wb.data pc ", op.name()}, w.data,
                    expect_alu(op, 32'h100, 32'hffff_f805));
    end
endtask

task automatic test_forwarding();
    wb_bus_t     w;
    logic [31:0] e [4];
    set_reg(1, 32'h0000_1001);
    set_reg(2, 32'h0200_0030);
    e[0] = 32'h0000_1001 + 32'h0200_0030; // r5 = r1 + r2.
    e[1] = e[0] + 32'h0000_1001;          // r6 = r5 + r1.
    e[2] = e[1] + e[0];                   // r7 = r6 + r5.
    e[3] = e[2] + e[1];                   // r5 = r7 + r6.
    issue(base_op(32'h200, 5, 1, 2));
    issue(base_op(32'h204, 6, 5, 1));
    issue(base_op(32'h208, 7, 6, 5));
    issue(base_op(32'h20c, 5, 7, 6));
    for (int i = 0; i < 4; i++) begin
        take_wb(w);
        check_value($sformatf("wb.data add %0d", i), w.data, e[i]);
    end
endtask

task automatic test_loads();
    dec_bus_t d;
    wb_bus_t  w;
    mem_op_e  op;
    int       stalls;
    set_reg(8, 32'h40);
    for (int k = int'(mem_lw); k <= int'(mem_lbu); k++) begin
        for (int ofs = 0; ofs < 4; ofs++) begin
            op = mem_op_e'(k);
            if ((op == mem_lw && ofs != 0) || (op inside {mem_lh, mem_lhu} && ofs[0])) begin
                continue;
            end
            d             = base_op(32'h300, 9, 8, 0);
            d.mem_op      = op;
            d.src2_is_imm = 1'b1;
            d.imm         = 32'h4 + ofs; // word 17.
            issue(d);
            take_wb(w);
            check_value($sformatf("wb.data %s +%0d", op.name(), ofs), w.data,
                        expect_load(op, ofs[1:0], mem[17]));
        end
    end
    d             = base_op(32'h320, 9, 8, 0);
    d.mem_op      = mem_lw;
    d.src2_is_imm = 1'b1;
    d.imm         = 32'h8;
    issue(d);
    send(base_op(32'h324, 10, 9, 8), stalls); // uses the load right away.
    check_true("exu_ready never dropped during the load-use stall", stalls > 0);
    take_wb(w);
    check_value("wb.data lw", w.data, mem[18]);
    take_wb(w);
    check_value("wb.data add after load", w.data, mem[18] + 32'h40);
endtask

task automatic store_check(input mem_op_e op, input logic [31:0] imm,
                           input logic [31:0] wdata, input logic [3:0] wstrb);
    dec_bus_t d;
    wb_bus_t  w;
    d             = base_op(32'h400, 0, 8, 11);
    d.mem_op      = op;
    d.src2_is_imm = 1'b1;
    d.imm         = imm;
    issue(d);
    take_wb(w);
    check_value("wb.pc", w.pc, 32'h400);
    check_value("wb.gpr_we", w.gpr_we, 0);
    check_value("mem_addr_bus.addr", seen_req.addr, 32'h40 + imm);
    check_value("mem_addr_bus.wdata", seen_req.wdata, wdata);
    check_value("mem_addr_bus.wstrb", seen_req.wstrb, wstrb);
    check_value("mem_addr_bus.we", seen_req.we, 1);
endtask

task automatic test_stores();
    dec_bus_t d;
    wb_bus_t  w;
    set_reg(8, 32'h40);
    set_reg(11, 32'ha1b2_c3d4);
    store_check(mem_sw, 32'h20, 32'ha1b2_c3d4, 4'b1111);
    store_check(mem_sh, 32'h22, 32'hc3d4_0000, 4'b1100);
    store_check(mem_sb, 32'h21, 32'hb2c3_d400, 4'b0010);
    d             = base_op(32'h410, 12, 8, 0);
    d.mem_op      = mem_lw;
    d.src2_is_imm = 1'b1;
    d.imm         = 32'h20;
    issue(d);
    take_wb(w);
    check_value("wb.data merged word", w.data, 32'hc3d4_d4d4);
endtask

task automatic release_redirect();
    pc_update <= 1'b1;
    @(posedge clk);
    pc_update <= 1'b0;
    @(negedge clk);
    check_value("redirect_valid", redirect_valid, 0);
    @(posedge clk);
endtask

task automatic jump_check(input br_op_e op, input logic [31:0] pc, input logic [3:0] rs1,
                          input logic [31:0] imm, input logic [31:0] target);
    dec_bus_t d;
    wb_bus_t  w;
    d             = base_op(pc, 13, rs1, 0);
    d.br_op       = op;
    d.src2_is_imm = 1'b1;
    d.imm         = imm;
    issue(d);
    take_wb(w);
    check_value({"wb.data ", op.name()}, w.data, pc + 32'd4);
    check_value("wb.pc", w.pc, pc);
    @(negedge clk);
    check_value("redirect_valid", redirect_valid, 1);
    check_value("redirect_pc", redirect_pc, target);
    @(posedge clk);
    release_redirect();
endtask

task automatic test_branches();
    dec_bus_t d;
    wb_bus_t  w;
    set_reg(1, 32'h5);
    set_reg(2, 32'h5);
    set_reg(8, 32'h40);
    d       = base_op(32'h500, 0, 1, 2);
    d.br_op = br_beq;
    d.imm   = 32'h40;
    issue(d);
    take_wb(w);
    @(negedge clk);
    check_value("redirect_valid", redirect_valid, 1);
    check_value("redirect_pc", redirect_pc, 32'h540);
    @(posedge clk);
    d             = base_op(32'h504, 3, 0, 0); // wrong path.
    d.src2_is_imm = 1'b1;
    d.imm         = 32'h77;
    issue(d);
    repeat (6) @(posedge clk);
    check_true("an instruction sent during a redirect wrote back", wb_q.size() == 0);
    release_redirect();
    d       = base_op(32'h540, 0, 1, 2);
    d.br_op = br_bne;
    d.imm   = 32'h40;
    issue(d);
    take_wb(w);
    @(negedge clk);
    check_value("redirect_valid", redirect_valid, 0);
    @(posedge clk);
    jump_check(br_jal, 32'h600, 0, 32'h100, 32'h700);
    jump_check(br_jalr, 32'h700, 8, 32'h10, 32'h50);
endtask

task automatic csr_check(input csr_op_e op, input logic [3:0] rs1,
                         input logic [31:0] old, input logic [31:0] wdata);
    dec_bus_t d;
    wb_bus_t  w;
    d          = base_op(32'h800, 15, rs1, 0);
    d.csr_op   = op;
    d.imm      = 32'h305;
    d.csr_data = old;
    issue(d);
    take_wb(w);
    check_value("wb.data", w.data, old);
    check_value("wb.pc", w.pc, 32'h800);
    check_value("wb.rd", w.rd, 15);
    check_value("wb.gpr_we", w.gpr_we, 1);
    check_value("wb.csr_we", w.csr_we, 1);
    check_value("wb.csr_addr", w.csr_addr, 32'h305);
    check_value("wb.csr_wdata", w.csr_wdata, wdata);
endtask

task automatic test_csr();
    set_reg(11, 32'ha1b2_c3d4);
    csr_check(csr_rw, 11, 32'h1111_0000, 32'ha1b2_c3d4);
    csr_check(csr_rs, 15, 32'h0000_00f0, 32'h1111_00f0); // rs1 is the csrrw result.
endtask

// File: tb/tb_exec_top.sv
module tb_exec_top import exec_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic            clk;
    logic            rst;
    logic            dec_valid;
    dec_bus_t        dec;
    logic            exu_ready;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            pc_update;
    logic            mem_req;
    mem_req_t        mem_addr_bus;
    logic            mem_ack = 1'b0;
    logic [XLEN-1:0] mem_rdata = '0;
    logic            wb_valid;
    wb_bus_t         wb;

    logic [XLEN-1:0] mem [64];
    logic [XLEN-1:0] rf [16];           // register file as decode sees it.
    wb_bus_t         wb_q [$];
    mem_req_t        seen_req;          // last request the responder acknowledged.
    logic [31:0]     lcg_state = 32'h8134493f;
    int              resp_delay;
    int              errors = 0;
    int              checks = 0;

    exec_top #(
        .BYPASS_DEPTH (4)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] m;
        m = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                m[8*i +: 8] = data[8*i +: 8];
            end
        end
        return m;
    endfunction

    // memory responder, one phase at a time after 0 to 3 idle cycles.
    always @(posedge clk) begin
        if (rst) begin
            mem_ack    <= 1'b0;
            resp_delay <= 0;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= 32'h9e37_79b9 * (i + 7);
            end
        end else if (mem_req != mem_ack) begin
            if (resp_delay > 0) begin
                resp_delay <= resp_delay - 1;
            end else begin
                lcg_state  <= lcg_next(lcg_state);
                resp_delay <= lcg_state[17:16];
                mem_ack    <= mem_req;
                if (mem_req) begin
                    seen_req  <= mem_addr_bus;
                    mem_rdata <= mem[mem_addr_bus.addr[7:2]];
                    if (mem_addr_bus.we) begin
                        mem[mem_addr_bus.addr[7:2]] <= merge_bytes(mem[mem_addr_bus.addr[7:2]],
                            mem_addr_bus.wdata, mem_addr_bus.wstrb);
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                rf[i] = '0;
            end
        end else if (wb_valid) begin
            wb_q.push_back(wb);
            if (wb.gpr_we && wb.rd != '0) begin
                rf[wb.rd] = wb.data; // lags the bypass window.
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input string failure, input logic cond);
        checks++;
        if (!cond) begin
            errors++;
            $display("ERROR: %s", failure);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("ERROR: timed out waiting for %s", what);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("TB FAILED");
        $finish;
    endtask

    // drives one instruction and returns once it has transferred.
    task automatic send(input dec_bus_t d, output int stalls);
        logic ready;
        d.src1_r = rf[d.rs1];
        d.src2_r = rf[d.rs2];
        dec       <= d;
        dec_valid <= 1'b1;
        stalls = 0;
        do begin
            @(negedge clk);
            ready = exu_ready;
            @(posedge clk);
            if (!ready) begin
                stalls++;
                if (stalls > TIMEOUT) begin
                    abort_on_timeout("exu_ready");
                end
            end
        end while (!ready);
        dec_valid <= 1'b0;
    endtask

    task automatic issue(input dec_bus_t d);
        int stalls;
        send(d, stalls);
    endtask

    task automatic take_wb(output wb_bus_t w);
        int t;
        t = 0;
        while (wb_q.size() == 0) begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) begin
                abort_on_timeout("wb_valid");
            end
        end
        w = wb_q.pop_front();
    endtask

    function automatic dec_bus_t base_op(input logic [31:0] pc, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2);
        dec_bus_t d;
        d        = '0;   // add, no branch, no memory, no csr.
        d.pc     = pc;
        d.rd     = rd;
        d.rs1    = rs1;
        d.rs2    = rs2;
        d.gpr_we = rd != '0;
        return d;
    endfunction

    task automatic set_reg(input logic [3:0] r, input logic [31:0] v);
        dec_bus_t d;
        wb_bus_t  w;
        d             = base_op(32'h0, r, 0, 0);
        d.src2_is_imm = 1'b1;
        d.imm         = v;
        issue(d);
        take_wb(w);
        check_value("wb.data", w.data, v);
    endtask

    `include "tb_exec_tests.svh"

    initial begin
        rst       = 1'b1;
        dec_valid = 1'b0;
        dec       = '0;
        pc_update = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_true("outputs not idle after reset",
                   exu_ready && !wb_valid && !mem_req && !redirect_valid);
        @(posedge clk);
        test_alu();
        test_forwarding();
        test_loads();
        test_stores();
        test_branches();
        test_csr();
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
